//--- design/ifu_pkg.sv
/*
 Widths, types and encodings shared by the instruction fetch unit.
 RV32I only. Compressed instructions are not decoded.
*/
package ifu_pkg;

    localparam int ADDR_W = 32;                // instruction address width
    localparam int DATA_W = 32;                // instruction word width
    localparam int CU_W   = 3;                 // control bus width
    localparam int OPC_W  = 7;                 // major opcode field

    typedef logic [ADDR_W-1:0] inst_addr_t;
    typedef logic [DATA_W-1:0] inst_data_t;
    typedef logic [CU_W-1:0]   cu_bus_t;
    typedef logic [OPC_W-1:0]  opcode_t;

    // control bus bit positions
    localparam int CU_STALL = 0;               // hold IF/ID
    localparam int CU_FLUSH = 1;               // kill IF/ID contents
    localparam int CU_HOLD  = 2;               // later stage stalled

    localparam inst_addr_t RESET_PC = 32'h0000_0000;  // first fetch
    localparam inst_data_t INST_NOP = 32'h0000_0013;  // addi x0,x0,0

    localparam opcode_t OPC_JAL    = 7'b110_1111;
    localparam opcode_t OPC_BRANCH = 7'b110_0011;    // beq/bne/blt/...

endpackage

//--- design/axi_pkg.sv
/*
 AXI read side encodings and the fetch master state machine type.
 Only OKAY counts as a good response.
*/
package axi_pkg;

    typedef logic [1:0] axi_resp_t;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;   // slave error, flagged to ID

    // read master states
    typedef enum logic [1:0] {
        FS_IDLE = 2'd0,                          // waiting for a clear control bus
        FS_ADDR = 2'd1,                          // ARVALID up, waiting for ARREADY
        FS_DATA = 2'd2                           // waiting for the R beat
    } fetch_state_e;

endpackage

//--- design/ifu_pc_gen.sv
`timescale 1ns/100ps
/*
 Fetch PC register. A core jump beats a predicted jump.
 Without a redirect the PC moves by 4 only when the AXI master
 reports an accepted address beat.
*/
module ifu_pc_gen (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                core_jump_i,   // pulse from the core
    input  ifu_pkg::inst_addr_t core_addr_i,
    input  logic                pred_taken_i,  // from the predictor
    input  ifu_pkg::inst_addr_t pred_addr_i,
    input  logic                addr_accept_i, // AR handshake this cycle
    output ifu_pkg::inst_addr_t pc_o,
    output logic                redirect_o
);
    import ifu_pkg::*;

    inst_addr_t pc_q;
    inst_addr_t pc_d;

    assign redirect_o = core_jump_i | pred_taken_i;  // same cycle as the jump input
    assign pc_o       = pc_q;

    // fixed priority select
    always_comb begin
        pc_d = pc_q;
        if (core_jump_i) begin
            pc_d = core_addr_i;                      // core wins
        end else if (pred_taken_i) begin
            pc_d = pred_addr_i;
        end else if (addr_accept_i) begin
            pc_d = pc_q + 32'd4;                     // sequential
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    // targets come from the core and the predictor, both must keep alignment
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset_i)
        redirect_o |=> (pc_q[1:0] == 2'b00))
        else $error("ifu_pc_gen: pc %h not word aligned", pc_q);

endmodule

//--- design/ifu_axi_master.sv
`timescale 1ns/100ps
/*
 Single-beat AXI read master, one read in flight at most.
 Assumes word-sized INCR reads with ID 0 on the slave side.
 A core jump in the same cycle as the R beat does not drop that beat,
 the core is expected to flush IF/ID together with such a jump.
*/
module ifu_axi_master (
    input  logic                clk,
    input  logic                reset_i,
    input  ifu_pkg::cu_bus_t    stall_flag_i,
    input  logic                redirect_i,        // core or predicted jump
    input  ifu_pkg::inst_addr_t pc_i,
    output logic                addr_accept_o,     // AR handshake of a live address
    output ifu_pkg::inst_data_t inst_o,
    output ifu_pkg::inst_addr_t inst_addr_o,
    output logic                inst_valid_o,      // one cycle per kept beat
    output logic                read_resp_error_o,
    // read address channel
    output ifu_pkg::inst_addr_t m_axi_araddr_o,
    output logic                m_axi_arvalid_o,
    input  logic                m_axi_arready_i,
    // read data channel
    input  ifu_pkg::inst_data_t m_axi_rdata_i,
    input  axi_pkg::axi_resp_t  m_axi_rresp_i,
    input  logic                m_axi_rlast_i,
    input  logic                m_axi_rvalid_i,
    output logic                m_axi_rready_o
);
    import ifu_pkg::*;
    import axi_pkg::*;

    fetch_state_e state_q;
    fetch_state_e state_d;
    inst_addr_t   araddr_q;     // address of the read in flight
    logic         discard_q;    // read went stale after a redirect
    logic         any_stall;
    logic         r_beat;

    assign any_stall = stall_flag_i[CU_STALL] | stall_flag_i[CU_FLUSH]
                     | stall_flag_i[CU_HOLD];

    assign m_axi_arvalid_o = (state_q == FS_ADDR);            // held until ARREADY
    assign m_axi_araddr_o  = araddr_q;
    assign m_axi_rready_o  = (state_q == FS_DATA) && !any_stall;  // back-pressure

    // a stale address must not move the pc past a redirect target
    assign addr_accept_o = m_axi_arvalid_o & m_axi_arready_i & ~discard_q;
    assign r_beat        = m_axi_rvalid_i & m_axi_rready_o;

    // stale beats are taken off the bus but not passed on
    assign inst_valid_o = r_beat & ~discard_q;
    assign inst_o       = m_axi_rdata_i;
    assign inst_addr_o  = araddr_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            FS_IDLE: begin
                if (!any_stall && !redirect_i) begin
                    state_d = FS_ADDR;                    // pc is settled
                end
            end
            FS_ADDR: begin
                if (m_axi_arready_i) begin
                    state_d = FS_DATA;
                end
            end
            FS_DATA: begin
                if (r_beat) begin
                    state_d = FS_IDLE;
                end
            end
            default: begin
                state_d = FS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q           <= FS_IDLE;
            discard_q         <= 1'b0;
            read_resp_error_o <= 1'b0;
        end else begin
            state_q           <= state_d;
            read_resp_error_o <= inst_valid_o && (m_axi_rresp_i != RESP_OKAY);
            if (r_beat) begin
                discard_q <= 1'b0;                        // read retired
            end else if (redirect_i && (state_q != FS_IDLE)) begin
                discard_q <= 1'b1;                        // issued address now stale
            end
        end
    end

    // latch pc when leaving idle, no reset needed on the address
    always_ff @(posedge clk) begin
        if (state_q == FS_IDLE && state_d == FS_ADDR) begin
            araddr_q <= pc_i;
        end
    end

    a_ar_stable: assert property (@(posedge clk) disable iff (reset_i)
        m_axi_arvalid_o && !m_axi_arready_i |=>
            m_axi_arvalid_o && $stable(m_axi_araddr_o))
        else $error("ifu_axi_master: AR changed before ARREADY");

    a_rlast: assert property (@(posedge clk) disable iff (reset_i)
        r_beat |-> m_axi_rlast_i)
        else $error("ifu_axi_master: R beat without RLAST");

endmodule

//--- design/ifu_sbpu.sv
`timescale 1ns/100ps
/*
 Static branch predictor, purely combinational.
 JAL is always taken, B-type is taken only when its offset is negative.
 JALR is not predicted.
*/
module ifu_sbpu (
    input  ifu_pkg::inst_data_t inst_i,
    input  ifu_pkg::inst_addr_t pc_i,
    input  logic                inst_valid_i,
    output logic                branch_taken_o,
    output ifu_pkg::inst_addr_t branch_addr_o
);
    import ifu_pkg::*;

    opcode_t    opcode;
    inst_addr_t imm_j;          // sign-extended J-type offset
    inst_addr_t imm_b;          // sign-extended B-type offset
    logic       is_jal;
    logic       is_bwd_branch;

    assign opcode = inst_i[6:0];

    // imm[20|10:1|11|19:12], bit 0 is zero
    assign imm_j = {{11{inst_i[31]}},
                    inst_i[31],
                    inst_i[19:12],
                    inst_i[20],
                    inst_i[30:21],
                    1'b0};

    // imm[12|10:5] and imm[4:1|11]
    assign imm_b = {{19{inst_i[31]}},
                    inst_i[31],
                    inst_i[7],
                    inst_i[30:25],
                    inst_i[11:8],
                    1'b0};

    assign is_jal        = (opcode == OPC_JAL);
    assign is_bwd_branch = (opcode == OPC_BRANCH) && inst_i[31];  // sign bit set

    // only a live fetch may redirect
    assign branch_taken_o = inst_valid_i & (is_jal | is_bwd_branch);

    always_comb begin
        if (is_jal) begin
            branch_addr_o = pc_i + imm_j;
        end else begin
            branch_addr_o = pc_i + imm_b;    // don't care unless taken
        end
    end

endmodule

//--- design/ifu_pipe.sv
`timescale 1ns/100ps
/*
 IF/ID register. Flush beats stall, stall beats a new word.
 A cycle without a fetched word loads a NOP bubble at address 0.
*/
module ifu_pipe (
    input  logic                clk,
    input  logic                reset_i,
    input  ifu_pkg::cu_bus_t    stall_flag_i,
    input  ifu_pkg::inst_data_t inst_i,
    input  ifu_pkg::inst_addr_t inst_addr_i,
    input  logic                inst_valid_i,
    input  logic                is_pred_branch_i,
    output ifu_pkg::inst_data_t inst_o,
    output ifu_pkg::inst_addr_t inst_addr_o,
    output logic                is_pred_branch_o
);
    import ifu_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_i || stall_flag_i[CU_FLUSH]) begin
            inst_o           <= INST_NOP;       // flushed slot
            inst_addr_o      <= '0;
            is_pred_branch_o <= 1'b0;
        end else if (!stall_flag_i[CU_STALL]) begin  // held while CU_STALL
            if (inst_valid_i) begin
                inst_o           <= inst_i;
                inst_addr_o      <= inst_addr_i;
                is_pred_branch_o <= is_pred_branch_i;
            end else begin
                inst_o           <= INST_NOP;   // bubble
                inst_addr_o      <= '0;
                is_pred_branch_o <= 1'b0;
            end
        end
    end

    // the master must hold RREADY low whenever any control bit is set
    a_no_fetch_in_stall: assert property (@(posedge clk) disable iff (reset_i)
        inst_valid_i |-> (stall_flag_i == '0))
        else $error("ifu_pipe: fetch completed under stall bus %b", stall_flag_i);

endmodule

//--- design/ifu.sv
`timescale 1ns/100ps
/*
 Instruction fetch unit top. One single-beat AXI read at a time.
 Constant AXI attributes (ID, LEN, SIZE, BURST, ...) are not on the ports.
*/
module ifu (
    input  logic                clk,
    input  logic                reset_i,
    // core control
    input  logic                jump_flag_i,        // pulse
    input  ifu_pkg::inst_addr_t jump_addr_i,
    input  ifu_pkg::cu_bus_t    stall_flag_i,
    // to ID
    output ifu_pkg::inst_data_t inst_o,
    output ifu_pkg::inst_addr_t inst_addr_o,
    output logic                is_pred_branch_o,
    output logic                read_resp_error_o,
    // AXI read address channel
    output ifu_pkg::inst_addr_t m_axi_araddr_o,
    output logic                m_axi_arvalid_o,
    input  logic                m_axi_arready_i,
    // AXI read data channel
    input  ifu_pkg::inst_data_t m_axi_rdata_i,
    input  axi_pkg::axi_resp_t  m_axi_rresp_i,
    input  logic                m_axi_rlast_i,
    input  logic                m_axi_rvalid_i,
    output logic                m_axi_rready_o
);
    import ifu_pkg::*;

    inst_addr_t pc;
    logic       redirect;
    logic       addr_accept;
    inst_data_t fetch_inst;       // word from the R beat
    inst_addr_t fetch_addr;       // its address
    logic       fetch_valid;
    logic       branch_taken;     // predictor decision
    inst_addr_t branch_addr;

    ifu_pc_gen u_pc_gen (
        .clk          (clk),
        .reset_i      (reset_i),
        .core_jump_i  (jump_flag_i),
        .core_addr_i  (jump_addr_i),
        .pred_taken_i (branch_taken),
        .pred_addr_i  (branch_addr),
        .addr_accept_i(addr_accept),
        .pc_o         (pc),
        .redirect_o   (redirect)
    );

    ifu_axi_master u_axi_master (
        .clk              (clk),
        .reset_i          (reset_i),
        .stall_flag_i     (stall_flag_i),
        .redirect_i       (redirect),
        .pc_i             (pc),
        .addr_accept_o    (addr_accept),
        .inst_o           (fetch_inst),
        .inst_addr_o      (fetch_addr),
        .inst_valid_o     (fetch_valid),
        .read_resp_error_o(read_resp_error_o),
        .m_axi_araddr_o   (m_axi_araddr_o),
        .m_axi_arvalid_o  (m_axi_arvalid_o),
        .m_axi_arready_i  (m_axi_arready_i),
        .m_axi_rdata_i    (m_axi_rdata_i),
        .m_axi_rresp_i    (m_axi_rresp_i),
        .m_axi_rlast_i    (m_axi_rlast_i),
        .m_axi_rvalid_i   (m_axi_rvalid_i),
        .m_axi_rready_o   (m_axi_rready_o)
    );

    ifu_sbpu u_sbpu (
        .inst_i        (fetch_inst),
        .pc_i          (fetch_addr),
        .inst_valid_i  (fetch_valid),
        .branch_taken_o(branch_taken),
        .branch_addr_o (branch_addr)
    );

    ifu_pipe u_pipe (
        .clk             (clk),
        .reset_i         (reset_i),
        .stall_flag_i    (stall_flag_i),
        .inst_i          (fetch_inst),
        .inst_addr_i     (fetch_addr),
        .inst_valid_i    (fetch_valid),
        .is_pred_branch_i(branch_taken),    // taken prediction rides along
        .inst_o          (inst_o),
        .inst_addr_o     (inst_addr_o),
        .is_pred_branch_o(is_pred_branch_o)
    );

endmodule

//--- bench/tb_clk_gen.sv
`timescale 1ns/100ps
/*
 Bench clock and synchronous reset source.
 Reset drops 1 ns after the last reset edge.
*/
module tb_clk_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic reset_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 reset_o = 1'b0;                      // off the edge like other inputs
    end

endmodule

//--- bench/tb_axi_mem.sv
`timescale 1ns/100ps
/*
 AXI read slave model, one read in flight, single beats only.
 ARREADY and RVALID each come after 0 to 3 random cycles.
 Program image is computed, one address answers SLVERR.
*/
module tb_axi_mem #(
    parameter logic [31:0] ERR_ADDR = 32'h0000_00a0
) (
    input  logic               clk_i,
    input  logic               reset_i,
    input  logic [31:0]        araddr_i,
    input  logic               arvalid_i,
    output logic               arready_o,
    output logic [31:0]        rdata_o,
    output axi_pkg::axi_resp_t rresp_o,
    output logic               rlast_o,
    output logic               rvalid_o,
    input  logic               rready_i,
    input  logic [31:0]        lookup_addr_i,   // checker side port
    output logic [31:0]        lookup_word_o
);
    import axi_pkg::*;

    localparam logic [31:0] JAL_ADDR = 32'h0000_0040;   // jal +0x40
    localparam logic [31:0] BWD_ADDR = 32'h0000_00c0;   // beq -0x80, back to JAL_ADDR
    localparam logic [31:0] FWD_ADDR = 32'h0000_0100;   // beq +0x20, not predicted

    logic [31:0] req_addr;
    logic [31:0] ar_addr_seen;
    logic        req_pend;
    logic [1:0]  ar_cnt;
    logic [1:0]  r_cnt;
    logic        ar_hs;
    logic        r_hs;

    function automatic logic [31:0] enc_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b110_1111};
    endfunction

    function automatic logic [31:0] enc_beq(input logic [12:0] off);
        return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], 7'b110_0011};
    endfunction

    // addi x1,x0,imm with imm folded from the whole address, never a NOP
    function automatic logic [31:0] prog_word(input logic [31:0] addr);
        case (addr)
            JAL_ADDR: return enc_jal(21'd64);
            BWD_ADDR: return enc_beq(13'h1f80);        // -128
            FWD_ADDR: return enc_beq(13'd32);
            default:  return {addr[11:2] ^ addr[21:12] ^ addr[31:22], 1'b1, ^addr[1:0],
                              5'd0, 3'b000, 5'd1, 7'b001_0011};
        endcase
    endfunction

    assign lookup_word_o = prog_word(lookup_addr_i);

    initial begin
        arready_o = 1'b0;
        rvalid_o  = 1'b0;
        rlast_o   = 1'b0;
        rdata_o   = '0;
        rresp_o   = RESP_OKAY;
        req_pend  = 1'b0;
        ar_cnt    = '0;
        r_cnt     = '0;
    end

    always @(posedge clk_i) begin
        ar_hs        = arvalid_i & arready_o;       // handshakes as seen at the edge
        r_hs         = rvalid_o & rready_i;
        ar_addr_seen = araddr_i;
        #1;
        if (reset_i) begin
            arready_o = 1'b0;
            rvalid_o  = 1'b0;
            rlast_o   = 1'b0;
            req_pend  = 1'b0;
            ar_cnt    = 2'($urandom_range(3, 0));
        end else begin
            if (r_hs) begin
                rvalid_o = 1'b0;
                rlast_o  = 1'b0;
            end
            if (ar_hs) begin
                arready_o = 1'b0;
                req_addr  = ar_addr_seen;
                req_pend  = 1'b1;
                r_cnt     = 2'($urandom_range(3, 0));
                ar_cnt    = 2'($urandom_range(3, 0));
            end else if (arvalid_i && !arready_o) begin
                if (ar_cnt == 2'd0) arready_o = 1'b1;
                else ar_cnt = ar_cnt - 2'd1;
            end
            if (req_pend && !rvalid_o) begin
                if (r_cnt == 2'd0) begin
                    rvalid_o = 1'b1;                // held until RREADY
                    rlast_o  = 1'b1;
                    rdata_o  = prog_word(req_addr);
                    rresp_o  = (req_addr == ERR_ADDR) ? RESP_SLVERR : RESP_OKAY;
                    req_pend = 1'b0;
                end else begin
                    r_cnt = r_cnt - 2'd1;
                end
            end
        end
    end

endmodule

//--- bench/tb_ifu.sv
`timescale 1ns/100ps
/*
 IFU testbench. Concurrent assertions do all checks.
 Every core jump comes with a flush.
*/
module tb_ifu;
    import ifu_pkg::*;
    import axi_pkg::*;

    localparam int          NUM_CYCLES  = 2000;
    localparam int          WATCHDOG_NS = 3000 * 4;
    localparam logic [31:0] ERR_ADDR    = 32'h0000_00a0;

    logic clk, reset_i, jump_flag, is_pred_branch, read_resp_error;
    logic arvalid, arready, rlast, rvalid, rready;
    inst_addr_t jump_addr, inst_addr, araddr, next_exp, jump_tgt;
    inst_data_t inst, rdata, chk_word;
    cu_bus_t    stall_flag, prev_cu;
    axi_resp_t  rresp;
    logic       have_last, jump_pend, new_deliv;
    int         deliv_cnt, pred_cnt, err_cnt, hold_cnt, r;

    tb_clk_gen clk_gen_i (.clk_o(clk), .reset_o(reset_i));

    tb_axi_mem #(.ERR_ADDR(ERR_ADDR)) mem_i (
        .clk_i(clk), .reset_i(reset_i),
        .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
        .rdata_o(rdata), .rresp_o(rresp), .rlast_o(rlast),
        .rvalid_o(rvalid), .rready_i(rready),
        .lookup_addr_i(inst_addr), .lookup_word_o(chk_word)
    );

    ifu dut_i (
        .clk(clk), .reset_i(reset_i),
        .jump_flag_i(jump_flag), .jump_addr_i(jump_addr), .stall_flag_i(stall_flag),
        .inst_o(inst), .inst_addr_o(inst_addr), .is_pred_branch_o(is_pred_branch),
        .read_resp_error_o(read_resp_error),
        .m_axi_araddr_o(araddr), .m_axi_arvalid_o(arvalid), .m_axi_arready_i(arready),
        .m_axi_rdata_i(rdata), .m_axi_rresp_i(rresp), .m_axi_rlast_i(rlast),
        .m_axi_rvalid_i(rvalid), .m_axi_rready_o(rready)
    );

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        $display("TEST FAIL");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic report_failure(input string what);
        $display("%s at %0t ns", what, $time);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    // JAL, or B-type with negative offset
    function automatic logic expect_pred(input inst_data_t w);
        return (w[6:0] == 7'b110_1111) || (w[6:0] == 7'b110_0011 && w[31]);
    endfunction

    function automatic inst_addr_t branch_target(input inst_data_t w, input inst_addr_t a);
        if (w[6:0] == 7'b110_1111) begin
            return a + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        end
        return a + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    // word just loaded into IF/ID, not a held copy
    assign new_deliv = !reset_i && (prev_cu == '0) && (inst != INST_NOP);

    always @(posedge clk) begin
        if (reset_i) begin
            prev_cu   <= '0;
            have_last <= 1'b0;
            jump_pend <= 1'b0;
        end else begin
            prev_cu <= stall_flag;
            if (new_deliv) begin
                have_last <= 1'b1;
                next_exp  <= expect_pred(inst) ? branch_target(inst, inst_addr)
                                               : inst_addr + 32'd4;
                deliv_cnt <= deliv_cnt + 1;
                if (is_pred_branch) pred_cnt <= pred_cnt + 1;
                if (read_resp_error) err_cnt <= err_cnt + 1;
            end
            if (jump_flag) begin
                jump_pend <= 1'b1;                 // next word must be the target
                jump_tgt  <= jump_addr;
            end else if (new_deliv) begin
                jump_pend <= 1'b0;
            end
        end
    end

    a_content: assert property (@(posedge clk) disable iff (reset_i)
        inst != INST_NOP |-> inst == chk_word)
        else report_mismatch("inst_o", inst, chk_word);
    a_pred_flag: assert property (@(posedge clk) disable iff (reset_i)
        is_pred_branch == (inst != INST_NOP && expect_pred(inst)))
        else report_mismatch("is_pred_branch_o", 32'(is_pred_branch), 32'(!is_pred_branch));
    a_jump_target: assert property (@(posedge clk) disable iff (reset_i)
        new_deliv && jump_pend |-> inst_addr == jump_tgt)
        else report_mismatch("inst_addr_o", inst_addr, jump_tgt);
    a_sequence: assert property (@(posedge clk) disable iff (reset_i)
        new_deliv && !jump_pend && have_last |-> inst_addr == next_exp)
        else report_mismatch("inst_addr_o", inst_addr, next_exp);
    a_flush: assert property (@(posedge clk) disable iff (reset_i)
        stall_flag[CU_FLUSH] |=> inst == INST_NOP && !is_pred_branch)
        else report_failure("IF/ID not cleared one cycle after a flush");
    a_stall_hold: assert property (@(posedge clk) disable iff (reset_i)
        stall_flag[CU_STALL] && !stall_flag[CU_FLUSH] |=> $stable(inst) && $stable(inst_addr))
        else report_failure("IF/ID changed while stalled");
    a_no_fetch: assert property (@(posedge clk) disable iff (reset_i)
        stall_flag != '0 |-> !(rvalid && rready))
        else report_failure("read completed while a stall bit was set");
    a_resp_error: assert property (@(posedge clk) disable iff (reset_i)
        read_resp_error == (new_deliv && inst_addr == ERR_ADDR))
        else report_mismatch("read_resp_error_o", 32'(read_resp_error), 32'(!read_resp_error));

    initial begin
        #(WATCHDOG_NS);
        report_failure("timeout: run did not finish in time");
    end

    initial begin
        void'($urandom(32'h5aee));
        jump_flag  = 1'b0;
        jump_addr  = '0;
        stall_flag = '0;
        deliv_cnt  = 0;
        pred_cnt   = 0;
        err_cnt    = 0;
        hold_cnt   = 0;
        while (reset_i !== 1'b0) @(posedge clk);
        repeat (NUM_CYCLES) begin
            @(posedge clk);
            #1;
            jump_flag = 1'b0;
            r         = int'($urandom_range(99, 0));
            if (hold_cnt > 0) begin
                hold_cnt = hold_cnt - 1;              // keep the stall bus
            end else begin
                stall_flag = '0;
                if (r < 4) begin                      // jump in any fetch state
                    jump_flag            = 1'b1;
                    jump_addr            = 32'($urandom_range(127, 0)) << 2;
                    stall_flag[CU_FLUSH] = 1'b1;
                end else if (r < 7) begin
                    stall_flag[CU_FLUSH] = 1'b1;
                end else if (r < 17) begin
                    stall_flag = cu_bus_t'($urandom_range(7, 1));
                    hold_cnt   = int'($urandom_range(3, 0));
                end
            end
        end
        @(posedge clk);
        #1;
        jump_flag  = 1'b0;
        stall_flag = '0;
        repeat (20) @(posedge clk);
        if (deliv_cnt < 100 || pred_cnt == 0 || err_cnt == 0) begin
            report_failure("too few deliveries, predictions or error reads seen");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- src.f
design/ifu_pkg.sv
design/axi_pkg.sv
design/ifu_pc_gen.sv
design/ifu_axi_master.sv
design/ifu_sbpu.sv
design/ifu_pipe.sv
design/ifu.sv
bench/tb_clk_gen.sv
bench/tb_axi_mem.sv
bench/tb_ifu.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_ifu
FILELIST = src.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the fail message"
	@echo "  clean  remove build output and log"
	@echo "  help   this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
